/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_trig_support
FILELIST  = list.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
trig_pkg.sv
trig_csr_regs.sv
trig_decode.sv
trig_execute.sv
trig_result.sv
obi_attr_fifo.sv
trig_support_top.sv
tb_trig_support_properties.sv
tb_trig_support.sv

/* obi_attr_fifo.sv */
// OBI request attribute FIFO
// Stores one attribute per accepted request and hands it back
// alongside the in-order response that belongs to that request
`timescale 1ns/1ps

module obi_attr_fifo #(
  parameter type payload_t = logic
) (
  input  logic     in_support_if,
  input  logic     arst_n_i,
  input  logic     req_i,
  input  logic     gnt_i,
  input  logic     rvalid_i,
  input  payload_t attr_i,
  output payload_t attr_o
);

  payload_t                          mem [trig_pkg::ATTR_FIFO_DEPTH];
  logic [trig_pkg::ATTR_PTR_W-1:0]   wr_ptr;
  logic [trig_pkg::ATTR_PTR_W-1:0]   rd_ptr;
  logic [trig_pkg::ATTR_CNT_W-1:0]   count;
  logic                              push;
  logic                              pop;

  // Address phase completes on req and gnt, response phase on rvalid
  assign push = req_i && gnt_i && (count != trig_pkg::ATTR_CNT_W'(trig_pkg::ATTR_FIFO_DEPTH));
  assign pop  = rvalid_i && (count != '0);

  // Head entry only while a response is on the bus
  assign attr_o = pop ? mem[rd_ptr] : '0;

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == trig_pkg::ATTR_PTR_W'(trig_pkg::ATTR_FIFO_DEPTH - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == trig_pkg::ATTR_PTR_W'(trig_pkg::ATTR_FIFO_DEPTH - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      count <= count + trig_pkg::ATTR_CNT_W'(push) - trig_pkg::ATTR_CNT_W'(pop);
    end
  end

  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem[wr_ptr] <= attr_i;
    end
  end

endmodule

/* tb_trig_support.sv */
// Testbench for the debug trigger support block
// Programs triggers over Wishbone, retires instructions against a
// reference model and runs OBI traffic through both attribute FIFOs
`timescale 1ns/1ps

module tb_trig_support;

  logic                in_support_if;
  logic                arst_n_i;
  logic                wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [2:0]          wb_adr_i;
  trig_pkg::addr_t     wb_dat_i, wb_dat_o;
  logic                retire_valid_i, retire_mmode_i;
  trig_pkg::addr_t     retire_pc_i, retire_mem_addr_i;
  logic [3:0]          retire_rmask_i, retire_wmask_i;
  logic                match_valid_o, any_exec_o, any_load_o, any_store_o;
  trig_pkg::trig_vec_t hit_exec_o, hit_load_o, hit_store_o;
  logic                data_req_i, data_gnt_i, data_rvalid_i, data_we_i;
  logic                data_resp_was_store_o;
  logic                instr_req_i, instr_gnt_i, instr_rvalid_i;
  trig_pkg::addr_t     instr_addr_i, instr_resp_pc_o;

  // Shadow of the trigger registers as seen by the next retirement
  trig_pkg::addr_t     shadow_td1 [trig_pkg::NUM_TRIGGERS];
  trig_pkg::addr_t     shadow_td2 [trig_pkg::NUM_TRIGGERS];
  int                  n_exec_hits = 0;
  int                  n_ls_hits = 0;

  trig_support_top trig_support_top_i (.*);

  initial begin
    in_support_if = 1'b0;
    forever #2 in_support_if = ~in_support_if;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // --------------------
  // Reference model
  function automatic logic ref_cmp(input logic [31:0] a, input logic [31:0] thr,
                                   input logic [3:0] kind);
    case (kind)
      4'd0:    return a == thr;
      4'd2:    return a >= thr;
      4'd3:    return a < thr;
      default: return 1'b0;
    endcase
  endfunction

  // Expected {exec, load, store} hit vectors of one retirement
  function automatic logic [11:0] ref_match(input logic valid, input logic mmode,
                                            input logic [31:0] pc, input logic [31:0] addr,
                                            input logic [3:0] rmask, input logic [3:0] wmask);
    logic [3:0]  ex;
    logic [3:0]  ld;
    logic [3:0]  st;
    logic [31:0] td1;
    logic        active;
    ex = '0;
    ld = '0;
    st = '0;
    for (int t = 0; t < 4; t++) begin
      td1 = shadow_td1[t];
      active = valid && (td1[31:28] == 4'd2 || td1[31:28] == 4'd6) && (mmode ? td1[6] : td1[3]);
      ex[t] = active && td1[2] && ref_cmp(pc, shadow_td2[t], td1[10:7]);
      for (int b = 0; b < 4; b++) begin
        if (active && ref_cmp(addr + 32'(b), shadow_td2[t], td1[10:7])) begin
          ld[t] = ld[t] | (td1[0] & rmask[b]);
          st[t] = st[t] | (td1[1] & wmask[b]);
        end
      end
    end
    // An execute hit hides every load and store hit
    if (|ex) begin
      ld = '0;
      st = '0;
    end
    return {ex, ld, st};
  endfunction

  function automatic logic [31:0] make_tdata1(input logic [3:0] ttype, input logic [3:0] kind,
                                              input logic m, input logic u, input logic [2:0] esl);
    logic [31:0] v;
    v = '0;
    v[31:28] = ttype;
    v[10:7] = kind;
    v[6] = m;
    v[3] = u;
    v[2:0] = esl;
    return v;
  endfunction

  // --------------------
  // Stimulus tasks start and end 1 ns after a rising edge
  task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    waited = 0;
    {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = {2'b11, we, adr, wdata};
    do begin
      @(posedge in_support_if);
      #1;
      waited++;
      if (waited > 16) begin
        report_failure("Timeout waiting for Wishbone ack");
      end
    end while (!wb_ack_o);
    // Ack belongs in the cycle right after the request
    check_eq("wb_ack_o latency", 32'(waited), 32'd1);
    rdata = wb_dat_o;
    if (we && adr[0]) begin
      shadow_td2[adr[2:1]] = wdata;
    end else if (we) begin
      shadow_td1[adr[2:1]] = wdata;
    end
    // Master drops the cycle after the edge where it sees ack
    @(posedge in_support_if);
    #1;
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
  endtask

  task automatic wb_read_check(input logic [2:0] adr, input logic [31:0] exp);
    logic [31:0] rd;
    wb_access(1'b0, adr, 32'h0, rd);
    check_eq("wb_dat_o", rd, exp);
  endtask

  task automatic set_trigger(input logic [1:0] t, input logic [31:0] td1, input logic [31:0] td2);
    logic [31:0] rd;
    wb_access(1'b1, {t, 1'b0}, td1, rd);
    wb_access(1'b1, {t, 1'b1}, td2, rd);
  endtask

  task automatic retire(input logic valid, input logic mmode, input logic [31:0] pc,
                        input logic [31:0] addr, input logic [3:0] rmask, input logic [3:0] wmask);
    {retire_valid_i, retire_mmode_i, retire_pc_i} = {valid, mmode, pc};
    {retire_mem_addr_i, retire_rmask_i, retire_wmask_i} = {addr, rmask, wmask};
    @(posedge in_support_if);
    #1;
    retire_valid_i = 1'b0;
  endtask

  task automatic random_rewrite();
    logic [3:0] ttype;
    ttype = ($urandom_range(3, 0) == 0) ? 4'($urandom) : (1'($urandom) ? 4'd2 : 4'd6);
    set_trigger(2'($urandom), make_tdata1(ttype, 4'($urandom_range(3, 0)), 1'($urandom),
                1'($urandom), 3'($urandom)), 32'h100 + ($urandom & 32'h3F));
  endtask

  task automatic obi_traffic(input int n_req);
    logic        store_q [$];
    logic [31:0] pc_q [$];
    logic        d_exp;
    logic [31:0] i_exp;
    int          d_sent, i_sent, d_done, i_done, cycles;
    {d_sent, i_sent, d_done, i_done, cycles} = '0;
    while (d_done < n_req || i_done < n_req) begin
      cycles++;
      if (cycles > 4000) begin
        report_failure("Timeout waiting for OBI responses");
      end
      // A grant in the last cycle completed that address phase
      data_req_i = data_req_i && !data_gnt_i;
      instr_req_i = instr_req_i && !instr_gnt_i;
      data_rvalid_i = (store_q.size() > 0) && 1'($urandom);
      instr_rvalid_i = (pc_q.size() > 0) && 1'($urandom);
      if (!data_req_i && d_sent < n_req) begin
        data_req_i = 1'b1;
        data_we_i = 1'($urandom);
      end
      if (!instr_req_i && i_sent < n_req) begin
        instr_req_i = 1'b1;
        instr_addr_i = $urandom & 32'hFFFF_FFFC;
      end
      data_gnt_i = data_req_i && (store_q.size() < trig_pkg::ATTR_FIFO_DEPTH) && 1'($urandom);
      instr_gnt_i = instr_req_i && (pc_q.size() < trig_pkg::ATTR_FIFO_DEPTH) && 1'($urandom);
      if (data_gnt_i) begin
        store_q.push_back(data_we_i);
        d_sent++;
      end
      if (instr_gnt_i) begin
        pc_q.push_back(instr_addr_i);
        i_sent++;
      end
      #1;
      d_exp = data_rvalid_i ? store_q.pop_front() : 1'b0;
      i_exp = instr_rvalid_i ? pc_q.pop_front() : 32'h0;
      d_done += int'(data_rvalid_i);
      i_done += int'(instr_rvalid_i);
      check_eq("data_resp_was_store_o", 32'(data_resp_was_store_o), 32'(d_exp));
      check_eq("instr_resp_pc_o", instr_resp_pc_o, i_exp);
      @(posedge in_support_if);
      #1;
    end
    {data_req_i, data_gnt_i, data_rvalid_i, instr_req_i, instr_gnt_i, instr_rvalid_i} = '0;
  endtask

  // --------------------
  // Results appear one cycle after each retirement
  initial begin : compare_results
    logic [11:0] exp_hits;
    logic        exp_valid;
    exp_hits = '0;
    exp_valid = 1'b0;
    forever begin
      @(negedge in_support_if);
      if (trig_support_top_i.props_i.error_count != 0) begin
        report_failure("A protocol assertion on the DUT failed");
      end
      check_eq("match_valid_o", 32'(match_valid_o), 32'(exp_valid));
      if (exp_valid) begin
        check_eq("hit_exec_o", 32'(hit_exec_o), 32'(exp_hits[11:8]));
        check_eq("hit_load_o", 32'(hit_load_o), 32'(exp_hits[7:4]));
        check_eq("hit_store_o", 32'(hit_store_o), 32'(exp_hits[3:0]));
        check_eq("any_exec_o", 32'(any_exec_o), 32'(|exp_hits[11:8]));
        check_eq("any_load_o", 32'(any_load_o), 32'(|exp_hits[7:4]));
        check_eq("any_store_o", 32'(any_store_o), 32'(|exp_hits[3:0]));
        n_exec_hits += int'(|exp_hits[11:8]);
        n_ls_hits += int'(|exp_hits[7:0]);
      end
      exp_valid = arst_n_i && retire_valid_i;
      exp_hits = ref_match(retire_valid_i, retire_mmode_i, retire_pc_i, retire_mem_addr_i,
                           retire_rmask_i, retire_wmask_i);
    end
  end

  initial begin : stimulus
    logic [31:0] wdata [8];
    logic [31:0] rd;
    void'($urandom(32'h2439_bbc7));
    arst_n_i = 1'b0;
    {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = '0;
    {retire_valid_i, retire_mmode_i, retire_pc_i, retire_mem_addr_i} = '0;
    {retire_rmask_i, retire_wmask_i} = '0;
    {data_req_i, data_gnt_i, data_rvalid_i, data_we_i} = '0;
    {instr_req_i, instr_gnt_i, instr_rvalid_i, instr_addr_i} = '0;
    for (int t = 0; t < 4; t++) begin
      shadow_td1[t] = trig_pkg::TDATA1_DEFAULT;
      shadow_td2[t] = 32'h0;
    end
    repeat (5) @(posedge in_support_if);
    #1;
    arst_n_i = 1'b1;

    // Reset values followed by random write and read-back
    for (int a = 0; a < 8; a++) begin
      wb_read_check(3'(a), a[0] ? 32'h0 : trig_pkg::TDATA1_DEFAULT);
    end
    for (int a = 0; a < 8; a++) begin
      wdata[a] = $urandom;
      wb_access(1'b1, 3'(a), wdata[a], rd);
    end
    for (int a = 0; a < 8; a++) begin
      wb_read_check(3'(a), wdata[a]);
    end

    // Execute trigger over every match kind with one mode enabled
    for (int t = 1; t < 4; t++) begin
      set_trigger(2'(t), trig_pkg::TDATA1_DEFAULT, 32'h0);
    end
    for (int k = 0; k < 4; k++) begin
      for (int m = 0; m < 2; m++) begin
        set_trigger(2'd0, make_tdata1(m ? 4'd2 : 4'd6, 4'(k), 1'(m), 1'(1 - m), 3'b100),
                    32'h1000);
        for (int r = 0; r < 6; r++) begin
          retire(1'b1, 1'(r / 3), 32'h0FFC + 32'(4 * (r % 3)), 32'h0, 4'h0, 4'h0);
        end
      end
    end
    set_trigger(2'd0, make_tdata1(4'd15, 4'd0, 1'b1, 1'b1, 3'b111), 32'h1000);
    retire(1'b1, 1'b1, 32'h1000, 32'h1000, 4'hF, 4'hF);
    set_trigger(2'd0, make_tdata1(4'd3, 4'd0, 1'b1, 1'b1, 3'b111), 32'h1000);
    retire(1'b1, 1'b0, 32'h1000, 32'h1000, 4'hF, 4'hF);

    // Load and store on each byte lane under every mask
    set_trigger(2'd0, trig_pkg::TDATA1_DEFAULT, 32'h0);
    set_trigger(2'd1, make_tdata1(4'd6, 4'd0, 1'b1, 1'b1, 3'b011), 32'h2002);
    for (int off = 0; off < 4; off++) begin
      for (int msk = 0; msk < 16; msk++) begin
        retire(1'b1, 1'(off), 32'h500, 32'h2002 - 32'(off), 4'(msk), 4'(~msk));
      end
    end

    // Execute priority over load and store
    set_trigger(2'd0, make_tdata1(4'd2, 4'd0, 1'b1, 1'b1, 3'b100), 32'h2002);
    retire(1'b1, 1'b1, 32'h2002, 32'h2000, 4'hF, 4'hF);
    check_eq("any_exec_o", 32'(any_exec_o), 32'h1);
    check_eq("any_load_o", 32'(any_load_o), 32'h0);
    check_eq("any_store_o", 32'(any_store_o), 32'h0);

    // Random retirements with trigger rewrites in between
    for (int i = 0; i < 400; i++) begin
      if ($urandom_range(9, 0) == 0) begin
        random_rewrite();
      end
      retire($urandom_range(3, 0) != 0, 1'($urandom), 32'h100 + ($urandom & 32'h3F),
             32'h100 + ($urandom & 32'h3F), 4'($urandom), 4'($urandom));
    end

    obi_traffic(40);
    repeat (2) @(posedge in_support_if);
    #1;
    if (n_exec_hits == 0 || n_ls_hits == 0) begin
      $display("No trigger hits were seen during the run");
      $display("Regression failed");
      $fatal(1, "Stopped on missing trigger hits");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

/* tb_trig_support_properties.sv */
// Trigger support protocol assertions
// Wishbone ack shape, one cycle trigger result latency and the
// outstanding request bound of both attribute FIFOs
`timescale 1ns/1ps

module trig_support_props (
  input logic in_support_if,
  input logic arst_n_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic retire_valid_i,
  input logic match_valid_o,
  input logic data_req_i,
  input logic data_gnt_i,
  input logic data_rvalid_i,
  input logic instr_req_i,
  input logic instr_gnt_i,
  input logic instr_rvalid_i
);

  int error_count = 0;
  int data_out;
  int instr_out;

  function automatic void note_failure(input string what);
    $error("%s", what);
    error_count++;
  endfunction

  // Requests accepted and not yet answered
  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_out  <= 0;
      instr_out <= 0;
    end else begin
      data_out  <= data_out + int'(data_req_i && data_gnt_i) - int'(data_rvalid_i);
      instr_out <= instr_out + int'(instr_req_i && instr_gnt_i) - int'(instr_rvalid_i);
    end
  end

  ack_needs_request: assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
    else note_failure("wb_ack_o high without cyc and stb");

  ack_single_cycle: assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o)
    else note_failure("wb_ack_o high for two cycles");

  valid_one_cycle: assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    match_valid_o == $past(retire_valid_i))
    else note_failure("match_valid_o is not retire_valid_i delayed by one cycle");

  data_pop_not_empty: assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    data_rvalid_i |-> (data_out > 0))
    else note_failure("data response with no request outstanding");

  instr_pop_not_empty: assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    instr_rvalid_i |-> (instr_out > 0))
    else note_failure("instruction response with no request outstanding");

  data_push_not_full: assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    (data_req_i && data_gnt_i) |-> (data_out < trig_pkg::ATTR_FIFO_DEPTH))
    else note_failure("data request accepted with the FIFO full");

  instr_push_not_full: assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    (instr_req_i && instr_gnt_i) |-> (instr_out < trig_pkg::ATTR_FIFO_DEPTH))
    else note_failure("instruction request accepted with the FIFO full");

endmodule

bind trig_support_top trig_support_props props_i (
  .in_support_if (in_support_if), .arst_n_i (arst_n_i),
  .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_ack_o (wb_ack_o),
  .retire_valid_i (retire_valid_i), .match_valid_o (match_valid_o),
  .data_req_i (data_req_i), .data_gnt_i (data_gnt_i), .data_rvalid_i (data_rvalid_i),
  .instr_req_i (instr_req_i), .instr_gnt_i (instr_gnt_i), .instr_rvalid_i (instr_rvalid_i)
);

/* trig_csr_regs.sv */
// Trigger register bank
// Wishbone classic slave holding tdata1 and tdata2 for every trigger.
// Ack comes one cycle after cyc and stb, writes land on the ack edge.
`timescale 1ns/1ps

module trig_csr_regs (
  input  logic                                            in_support_if,
  input  logic                                            arst_n_i,
  input  logic                                            wb_cyc_i,
  input  logic                                            wb_stb_i,
  input  logic                                            wb_we_i,
  input  logic [2:0]                                      wb_adr_i,
  input  trig_pkg::addr_t                                 wb_dat_i,
  output logic                                            wb_ack_o,
  output trig_pkg::addr_t                                 wb_dat_o,
  output trig_pkg::addr_t [trig_pkg::NUM_TRIGGERS-1:0]    tdata1_o,
  output trig_pkg::addr_t [trig_pkg::NUM_TRIGGERS-1:0]    tdata2_o
);

  logic                           access;
  logic [trig_pkg::TRIG_IDX_W-1:0] sel;

  // New request seen and not yet acknowledged
  assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign sel    = wb_adr_i[trig_pkg::TRIG_IDX_W:1];

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= access;
    end
  end

  // --------------------
  // Register bank
  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tdata1_o <= {trig_pkg::NUM_TRIGGERS{trig_pkg::TDATA1_DEFAULT}};
      tdata2_o <= '0;
    end else if (access && wb_we_i) begin
      if (wb_adr_i[0]) begin
        tdata2_o[sel] <= wb_dat_i;
      end else begin
        tdata1_o[sel] <= wb_dat_i;
      end
    end
  end

  // Read data follows ack out of the same edge
  always_ff @(posedge in_support_if) begin
    if (access) begin
      wb_dat_o <= wb_adr_i[0] ? tdata2_o[sel] : tdata1_o[sel];
    end
  end

endmodule

/* trig_decode.sv */
// Trigger decode
// Turns each trigger's tdata1 fields and the retiring privilege mode
// into execute, load and store enables plus the match kind
`timescale 1ns/1ps

module trig_decode (
  input  trig_pkg::addr_t [trig_pkg::NUM_TRIGGERS-1:0]     tdata1_i,
  input  logic                                             retire_valid_i,
  input  logic                                             retire_mmode_i,
  output trig_pkg::trig_vec_t                              exec_en_o,
  output trig_pkg::trig_vec_t                              load_en_o,
  output trig_pkg::trig_vec_t                              store_en_o,
  output trig_pkg::match_kind_t [trig_pkg::NUM_TRIGGERS-1:0] match_kind_o
);

  logic [3:0]          trig_type [trig_pkg::NUM_TRIGGERS];
  trig_pkg::trig_vec_t type_ok;
  trig_pkg::trig_vec_t mode_ok;
  trig_pkg::trig_vec_t general_en;

  always_comb begin
    for (int t = 0; t < trig_pkg::NUM_TRIGGERS; t++) begin
      trig_type[t] = tdata1_i[t][trig_pkg::TDATA1_TYPE_MSB:trig_pkg::TDATA1_TYPE_LSB];
      // Only mcontrol and mcontrol6 compare addresses
      type_ok[t] = (trig_type[t] == trig_pkg::TYPE_MCONTROL) ||
                   (trig_type[t] == trig_pkg::TYPE_MCONTROL6);
      mode_ok[t] = retire_mmode_i ? tdata1_i[t][trig_pkg::TDATA1_M_MODE]
                                  : tdata1_i[t][trig_pkg::TDATA1_U_MODE];
      general_en[t] = retire_valid_i && type_ok[t] && mode_ok[t];

      exec_en_o[t]  = general_en[t] && tdata1_i[t][trig_pkg::TDATA1_EXECUTE];
      load_en_o[t]  = general_en[t] && tdata1_i[t][trig_pkg::TDATA1_LOAD];
      store_en_o[t] = general_en[t] && tdata1_i[t][trig_pkg::TDATA1_STORE];

      match_kind_o[t] = trig_pkg::match_kind_t'(
        tdata1_i[t][trig_pkg::TDATA1_MATCH_MSB:trig_pkg::TDATA1_MATCH_LSB]);
    end
  end

endmodule

/* trig_execute.sv */
// Trigger address compare
// Checks the pc and each byte of the memory access against tdata2 under
// the trigger's match kind, byte hits are qualified by rmask and wmask
`timescale 1ns/1ps

module trig_execute (
  input  trig_pkg::addr_t [trig_pkg::NUM_TRIGGERS-1:0]       tdata2_i,
  input  trig_pkg::match_kind_t [trig_pkg::NUM_TRIGGERS-1:0] match_kind_i,
  input  trig_pkg::addr_t                                    retire_pc_i,
  input  trig_pkg::addr_t                                    retire_mem_addr_i,
  input  logic [trig_pkg::ACCESS_BYTES-1:0]                  retire_rmask_i,
  input  logic [trig_pkg::ACCESS_BYTES-1:0]                  retire_wmask_i,
  output trig_pkg::trig_vec_t                                pc_match_o,
  output trig_pkg::trig_vec_t                                load_match_o,
  output trig_pkg::trig_vec_t                                store_match_o
);

  trig_pkg::addr_t [trig_pkg::ACCESS_BYTES-1:0]                            byte_addr;
  logic [trig_pkg::NUM_TRIGGERS-1:0][trig_pkg::ACCESS_BYTES-1:0]           byte_match;

  // Unsigned compare, undefined kinds never match
  function automatic logic addr_match(input trig_pkg::addr_t addr,
                                      input trig_pkg::addr_t thresh,
                                      input trig_pkg::match_kind_t kind);
    case (kind)
      trig_pkg::MATCH_EQ: return addr == thresh;
      trig_pkg::MATCH_GE: return addr >= thresh;
      trig_pkg::MATCH_LT: return addr < thresh;
      default:            return 1'b0;
    endcase
  endfunction

  always_comb begin
    // Byte addresses wrap at the top of the address space
    for (int b = 0; b < trig_pkg::ACCESS_BYTES; b++) begin
      byte_addr[b] = retire_mem_addr_i + trig_pkg::addr_t'(b);
    end

    for (int t = 0; t < trig_pkg::NUM_TRIGGERS; t++) begin
      pc_match_o[t] = addr_match(retire_pc_i, tdata2_i[t], match_kind_i[t]);
      for (int b = 0; b < trig_pkg::ACCESS_BYTES; b++) begin
        byte_match[t][b] = addr_match(byte_addr[b], tdata2_i[t], match_kind_i[t]);
      end
      load_match_o[t]  = |(byte_match[t] & retire_rmask_i);
      store_match_o[t] = |(byte_match[t] & retire_wmask_i);
    end
  end

endmodule

/* trig_pkg.sv */
// Debug trigger support package
// Trigger count, word types, match encodings and tdata1 field positions
// shared by the register bank, the trigger path and the attribute FIFOs
package trig_pkg;

  // --------------------
  // Sizes
  localparam int NUM_TRIGGERS = 4;
  localparam int TRIG_IDX_W = 2;
  localparam int XLEN = 32;
  localparam int ACCESS_BYTES = 4;

  // Outstanding OBI requests tracked per bus
  localparam int ATTR_FIFO_DEPTH = 4;
  localparam int ATTR_PTR_W = $clog2(ATTR_FIFO_DEPTH);
  localparam int ATTR_CNT_W = $clog2(ATTR_FIFO_DEPTH + 1);

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [NUM_TRIGGERS-1:0] trig_vec_t;

  // Match field encodings, all other values never match
  typedef enum logic [3:0] {
    MATCH_EQ = 4'd0,
    MATCH_GE = 4'd2,
    MATCH_LT = 4'd3
  } match_kind_t;

  // --------------------
  // tdata1 layout
  // Type 15 means the trigger is disabled
  localparam addr_t TDATA1_DEFAULT = 32'hF800_0000;

  localparam int TDATA1_LOAD = 0;
  localparam int TDATA1_STORE = 1;
  localparam int TDATA1_EXECUTE = 2;
  localparam int TDATA1_U_MODE = 3;
  localparam int TDATA1_M_MODE = 6;
  localparam int TDATA1_MATCH_LSB = 7;
  localparam int TDATA1_MATCH_MSB = 10;
  localparam int TDATA1_TYPE_LSB = 28;
  localparam int TDATA1_TYPE_MSB = 31;

  // Address match trigger types
  localparam logic [3:0] TYPE_MCONTROL = 4'd2;
  localparam logic [3:0] TYPE_MCONTROL6 = 4'd6;

endpackage

/* trig_result.sv */
// Trigger result stage
// Forms hit vectors, lets execute hits suppress load and store hits,
// and registers vectors, their OR and the valid flag
`timescale 1ns/1ps

module trig_result (
  input  logic                in_support_if,
  input  logic                arst_n_i,
  input  logic                retire_valid_i,
  input  trig_pkg::trig_vec_t exec_en_i,
  input  trig_pkg::trig_vec_t load_en_i,
  input  trig_pkg::trig_vec_t store_en_i,
  input  trig_pkg::trig_vec_t pc_match_i,
  input  trig_pkg::trig_vec_t load_match_i,
  input  trig_pkg::trig_vec_t store_match_i,
  output logic                match_valid_o,
  output trig_pkg::trig_vec_t hit_exec_o,
  output trig_pkg::trig_vec_t hit_load_o,
  output trig_pkg::trig_vec_t hit_store_o,
  output logic                any_exec_o,
  output logic                any_load_o,
  output logic                any_store_o
);

  trig_pkg::trig_vec_t exec_hit;
  trig_pkg::trig_vec_t load_hit;
  trig_pkg::trig_vec_t store_hit;

  assign exec_hit  = exec_en_i & pc_match_i;
  // Execute wins for the whole retirement
  assign load_hit  = (|exec_hit) ? '0 : (load_en_i & load_match_i);
  assign store_hit = (|exec_hit) ? '0 : (store_en_i & store_match_i);

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      match_valid_o <= 1'b0;
      hit_exec_o    <= '0;
      hit_load_o    <= '0;
      hit_store_o   <= '0;
      any_exec_o    <= 1'b0;
      any_load_o    <= 1'b0;
      any_store_o   <= 1'b0;
    end else begin
      match_valid_o <= retire_valid_i;
      hit_exec_o    <= exec_hit;
      hit_load_o    <= load_hit;
      hit_store_o   <= store_hit;
      any_exec_o    <= |exec_hit;
      any_load_o    <= |load_hit;
      any_store_o   <= |store_hit;
    end
  end

endmodule

/* trig_support_top.sv */
// Debug trigger and bus attribute support top level
// Wishbone trigger registers, decode/execute/result trigger path and
// the data store flag and instruction pc attribute FIFOs
`timescale 1ns/1ps

module trig_support_top (
  input  logic                              in_support_if,
  input  logic                              arst_n_i,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [2:0]                        wb_adr_i,
  input  trig_pkg::addr_t                   wb_dat_i,
  output logic                              wb_ack_o,
  output trig_pkg::addr_t                   wb_dat_o,
  input  logic                              retire_valid_i,
  input  trig_pkg::addr_t                   retire_pc_i,
  input  trig_pkg::addr_t                   retire_mem_addr_i,
  input  logic [trig_pkg::ACCESS_BYTES-1:0] retire_rmask_i,
  input  logic [trig_pkg::ACCESS_BYTES-1:0] retire_wmask_i,
  input  logic                              retire_mmode_i,
  output logic                              match_valid_o,
  output trig_pkg::trig_vec_t               hit_exec_o,
  output trig_pkg::trig_vec_t               hit_load_o,
  output trig_pkg::trig_vec_t               hit_store_o,
  output logic                              any_exec_o,
  output logic                              any_load_o,
  output logic                              any_store_o,
  input  logic                              data_req_i,
  input  logic                              data_gnt_i,
  input  logic                              data_rvalid_i,
  input  logic                              data_we_i,
  output logic                              data_resp_was_store_o,
  input  logic                              instr_req_i,
  input  logic                              instr_gnt_i,
  input  logic                              instr_rvalid_i,
  input  trig_pkg::addr_t                   instr_addr_i,
  output trig_pkg::addr_t                   instr_resp_pc_o
);

  trig_pkg::addr_t [trig_pkg::NUM_TRIGGERS-1:0]       tdata1;
  trig_pkg::addr_t [trig_pkg::NUM_TRIGGERS-1:0]       tdata2;
  trig_pkg::match_kind_t [trig_pkg::NUM_TRIGGERS-1:0] match_kind;
  trig_pkg::trig_vec_t exec_en, load_en, store_en;
  trig_pkg::trig_vec_t pc_match, load_match, store_match;

  trig_csr_regs trig_csr_regs_i (
    .in_support_if (in_support_if), .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
    .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
    .wb_ack_o (wb_ack_o), .wb_dat_o (wb_dat_o),
    .tdata1_o (tdata1), .tdata2_o (tdata2)
  );

  // --------------------
  // Trigger path
  trig_decode trig_decode_i (
    .tdata1_i (tdata1), .retire_valid_i (retire_valid_i), .retire_mmode_i (retire_mmode_i),
    .exec_en_o (exec_en), .load_en_o (load_en), .store_en_o (store_en),
    .match_kind_o (match_kind)
  );

  trig_execute trig_execute_i (
    .tdata2_i (tdata2), .match_kind_i (match_kind),
    .retire_pc_i (retire_pc_i), .retire_mem_addr_i (retire_mem_addr_i),
    .retire_rmask_i (retire_rmask_i), .retire_wmask_i (retire_wmask_i),
    .pc_match_o (pc_match), .load_match_o (load_match), .store_match_o (store_match)
  );

  trig_result trig_result_i (
    .in_support_if (in_support_if), .arst_n_i (arst_n_i), .retire_valid_i (retire_valid_i),
    .exec_en_i (exec_en), .load_en_i (load_en), .store_en_i (store_en),
    .pc_match_i (pc_match), .load_match_i (load_match), .store_match_i (store_match),
    .match_valid_o (match_valid_o), .hit_exec_o (hit_exec_o),
    .hit_load_o (hit_load_o), .hit_store_o (hit_store_o),
    .any_exec_o (any_exec_o), .any_load_o (any_load_o), .any_store_o (any_store_o)
  );

  // --------------------
  // Bus attribute tracking
  obi_attr_fifo #(.payload_t (logic)) data_store_fifo (
    .in_support_if (in_support_if), .arst_n_i (arst_n_i),
    .req_i (data_req_i), .gnt_i (data_gnt_i), .rvalid_i (data_rvalid_i),
    .attr_i (data_we_i), .attr_o (data_resp_was_store_o)
  );

  obi_attr_fifo #(.payload_t (trig_pkg::addr_t)) instr_pc_fifo (
    .in_support_if (in_support_if), .arst_n_i (arst_n_i),
    .req_i (instr_req_i), .gnt_i (instr_gnt_i), .rvalid_i (instr_rvalid_i),
    .attr_i (instr_addr_i), .attr_o (instr_resp_pc_o)
  );

endmodule
